/* all.f */
+incdir+.
iotdf_pkg.sv
byte_loader.sv
crc3_unit.sv
extreme_tracker.sv
output_stage.sv
iotdf_top.sv
tb_iotdf.sv

/* Bender.yml */
package:
  name: iotdf

sources:
  - files:
      - iotdf_pkg.sv
      - byte_loader.sv
      - crc3_unit.sv
      - extreme_tracker.sv
      - output_stage.sv
      - iotdf_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_iotdf.sv

/* tb_iotdf_ref.svh */
`ifndef TB_IOTDF_REF_SVH
`define TB_IOTDF_REF_SVH

// remainder of blk * x^3 divided by x^3 + x^2 + 1, msb first
function automatic crc_t ref_crc(input block_t blk);
  logic [BLOCK_W+CRC_W-1:0] rem;
  rem = {blk, {CRC_W{1'b0}}};
  for (int i = BLOCK_W + CRC_W - 1; i >= CRC_W; i--) begin
    if (rem[i]) begin
      rem[i -: CRC_W+1] = rem[i -: CRC_W+1] ^ {1'b1, CRC_POLY};
    end
  end
  return rem[CRC_W-1:0];
endfunction

// two best blocks of a group, ties count as separate entries
function automatic void ref_extremes(input block_t blocks [BLOCKS_PER_GROUP],
                                     input logic want_max,
                                     output block_t best,
                                     output block_t runner);
  block_t sorted [BLOCKS_PER_GROUP];
  block_t tmp;
  logic   swap;
  for (int i = 0; i < BLOCKS_PER_GROUP; i++) begin
    sorted[i] = blocks[i];
  end
  // insertion sort with the best entry at index 0
  for (int i = 1; i < BLOCKS_PER_GROUP; i++) begin
    for (int j = i; j > 0; j--) begin
      swap = want_max ? (sorted[j] > sorted[j-1]) : (sorted[j] < sorted[j-1]);
      if (swap) begin
        tmp         = sorted[j];
        sorted[j]   = sorted[j-1];
        sorted[j-1] = tmp;
      end
    end
  end
  best   = sorted[0];
  runner = sorted[1];
endfunction

`endif

/* tb_iotdf.sv */
`timescale 1ns/1ps

module tb_iotdf import iotdf_pkg::*; ();

  localparam logic [31:0] SEED = 32'h99d05e38;
  // 20 crc blocks, 6 min/max groups, 5 groups in the mode-change run
  localparam int NUM_GROUPS     = 31;
  localparam int TIMEOUT_CYCLES = 400 * NUM_GROUPS;
  localparam int BUSY_LEN       = 4;

  logic    i_clk = 1'b0;
  logic    i_rst;
  logic    i_in_en;
  byte_t   i_iot_in;
  fn_sel_t i_fn_sel;
  logic    o_busy;
  logic    o_valid;
  block_t  o_iot_out;

  block_t  exp_q [$];
  fn_sel_t cur_fn = FN_CRC_GEN;
  int      errors = 0;
  int      checks = 0;
  int      cycle_cnt = 0;
  int      busy_len = 0;

  `include "tb_iotdf_ref.svh"

  iotdf_top DUT (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in_en   (i_in_en),
    .i_iot_in  (i_iot_in),
    .i_fn_sel  (i_fn_sel),
    .o_busy    (o_busy),
    .o_valid   (o_valid),
    .o_iot_out (o_iot_out)
  );

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout after %0d cycles, results still outstanding: %0d",
             cycle_cnt, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  function automatic block_t rand_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // one byte, honoring busy and with optional idle cycles before it
  task automatic send_byte(input byte_t b, input logic gaps);
    int idle;
    while (o_busy) begin
      @(posedge i_clk);
      #1;
    end
    idle = gaps ? $urandom_range(0, 2) : 0;
    repeat (idle) begin
      @(posedge i_clk);
      #1;
    end
    i_in_en  = 1'b1;
    i_iot_in = b;
    @(posedge i_clk);
    #1;
    i_in_en  = 1'b0;
  endtask

  task automatic send_block(input block_t blk, input logic gaps);
    for (int k = 0; k < BYTES_PER_BLOCK; k++) begin
      send_byte(blk[k*BYTE_W +: BYTE_W], gaps);
    end
  endtask

  task automatic send_crc_block(input block_t blk, input logic gaps);
    while (o_busy) begin
      @(posedge i_clk);
      #1;
    end
    i_fn_sel = FN_CRC_GEN;
    cur_fn   = FN_CRC_GEN;
    exp_q.push_back({{(BLOCK_W - CRC_W){1'b0}}, ref_crc(blk)});
    send_block(blk, gaps);
  endtask

  task automatic send_group(input fn_sel_t fn, input block_t blocks [BLOCKS_PER_GROUP],
                            input logic gaps);
    block_t best;
    block_t runner;
    while (o_busy) begin
      @(posedge i_clk);
      #1;
    end
    i_fn_sel = fn;
    cur_fn   = fn;
    ref_extremes(blocks, fn == FN_TOP2MAX, best, runner);
    exp_q.push_back(best);
    exp_q.push_back(runner);
    for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
      send_block(blocks[b], gaps);
    end
    // busy follows the edge that took the last byte
    assert (o_busy === 1'b1) else begin
      errors++;
      $display("Mismatch at %0t: o_busy expected 1 actual %b", $time, o_busy);
    end
  endtask

  // result compare
  always @(negedge i_clk) begin : compare
    block_t want;
    if (!i_rst) begin
      if (o_valid) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("extra result at %0t, o_valid high with nothing expected", $time);
        end
        if (exp_q.size() != 0) begin
          want = exp_q.pop_front();
          checks++;
          assert (o_iot_out === want) else begin
            errors++;
            $display("Mismatch at %0t: o_iot_out expected %h actual %h",
                     $time, want, o_iot_out);
          end
        end
      end else begin
        assert (o_iot_out === '0) else begin
          errors++;
          $display("Mismatch at %0t: o_iot_out expected %h actual %h",
                   $time, block_t'(0), o_iot_out);
        end
      end
    end
  end

  // busy window length, and no busy in crc mode
  always @(negedge i_clk) begin
    if (!i_rst) begin
      assert (!(o_busy && cur_fn == FN_CRC_GEN)) else begin
        errors++;
        $display("Mismatch at %0t: o_busy expected 0 actual %b in crc mode", $time, o_busy);
      end
      if (o_busy) begin
        busy_len++;
      end else if (busy_len != 0) begin
        assert (busy_len == BUSY_LEN) else begin
          errors++;
          $display("busy window at %0t lasted %0d cycles instead of %0d",
                   $time, busy_len, BUSY_LEN);
        end
        busy_len = 0;
      end
    end
  end

  initial begin
    block_t blk;
    block_t grp [BLOCKS_PER_GROUP];
    block_t pool [3];
    void'($urandom(SEED));
    i_rst    = 1'b1;
    i_in_en  = 1'b0;
    i_iot_in = '0;
    i_fn_sel = FN_CRC_GEN;
    repeat (5) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    assert (o_valid === 1'b0) else begin
      errors++;
      $display("Mismatch at %0t: o_valid expected 0 actual %b", $time, o_valid);
    end
    assert (o_busy === 1'b0) else begin
      errors++;
      $display("Mismatch at %0t: o_busy expected 0 actual %b", $time, o_busy);
    end
    @(posedge i_clk);
    #1;

    // crc, back to back, idle gaps on the last few
    for (int n = 0; n < 20; n++) begin
      if (n == 0) begin
        blk = '0;
      end else if (n == 1) begin
        blk = '1;
      end else begin
        blk = rand_block();
      end
      send_crc_block(blk, n >= 15);
    end

    // top2max
    for (int g = 0; g < 3; g++) begin
      for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
        grp[b] = rand_block();
      end
      send_group(FN_TOP2MAX, grp, g == 2);
    end

    // last2min, plain then with repeats
    for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
      grp[b] = rand_block();
    end
    send_group(FN_LAST2MIN, grp, 1'b0);
    for (int i = 0; i < 3; i++) begin
      pool[i] = rand_block();
    end
    for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
      grp[b] = pool[$urandom_range(0, 2)];
    end
    send_group(FN_LAST2MIN, grp, 1'b1);
    for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
      grp[b] = rand_block();
    end
    grp[5] = grp[1];
    grp[7] = grp[1];
    send_group(FN_LAST2MIN, grp, 1'b0);

    // function changes at group boundaries
    for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
      grp[b] = rand_block();
    end
    send_group(FN_TOP2MAX, grp, 1'b0);
    send_crc_block(rand_block(), 1'b0);
    for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
      grp[b] = rand_block();
    end
    send_group(FN_LAST2MIN, grp, 1'b1);
    send_crc_block(rand_block(), 1'b1);
    for (int b = 0; b < BLOCKS_PER_GROUP; b++) begin
      grp[b] = rand_block();
    end
    send_group(FN_TOP2MAX, grp, 1'b0);

    // let the pipeline drain and catch late extras
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (8) @(posedge i_clk);
    $display("errors: %0d, results checked: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* iotdf_top.sv */
`timescale 1ns/1ps

module iotdf_top import iotdf_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_in_en,
  input  byte_t   i_iot_in,
  input  fn_sel_t i_fn_sel,
  output logic    o_busy,
  output logic    o_valid,
  output block_t  o_iot_out
);

  // decode to execute
  block_t  block;
  logic    block_strobe;
  logic    group_last;
  fn_sel_t fn;

  // execute to result
  crc_t   crc;
  logic   crc_valid;
  block_t first;
  block_t second;
  logic   pair_valid;

  byte_loader u_byte_loader (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_in_en        (i_in_en),
    .i_iot_in       (i_iot_in),
    .i_fn_sel       (i_fn_sel),
    .o_block        (block),
    .o_block_strobe (block_strobe),
    .o_group_last   (group_last),
    .o_fn           (fn),
    .o_busy         (o_busy)
  );

  crc3_unit u_crc3_unit (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_block        (block),
    .i_block_strobe (block_strobe),
    .i_fn           (fn),
    .o_crc          (crc),
    .o_crc_valid    (crc_valid)
  );

  extreme_tracker u_extreme_tracker (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_block        (block),
    .i_block_strobe (block_strobe),
    .i_group_last   (group_last),
    .i_fn           (fn),
    .o_first        (first),
    .o_second       (second),
    .o_pair_valid   (pair_valid)
  );

  output_stage u_output_stage (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_crc        (crc),
    .i_crc_valid  (crc_valid),
    .i_first      (first),
    .i_second     (second),
    .i_pair_valid (pair_valid),
    .o_valid      (o_valid),
    .o_iot_out    (o_iot_out)
  );

endmodule

/* output_stage.sv */
`timescale 1ns/1ps

module output_stage import iotdf_pkg::*; (
  input  logic   i_clk,
  input  logic   i_rst,
  input  crc_t   i_crc,
  input  logic   i_crc_valid,
  input  block_t i_first,
  input  block_t i_second,
  input  logic   i_pair_valid,
  output logic   o_valid,
  output block_t o_iot_out
);

  block_t pend_q;
  logic   pend_valid;

  // second of the pair waits one cycle
  always_ff @(posedge i_clk) begin
    if (i_pair_valid) begin
      pend_q <= i_second;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_valid    <= 1'b0;
      o_iot_out  <= '0;
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= 1'b0;
      if (i_crc_valid) begin
        o_valid   <= 1'b1;
        o_iot_out <= {{(BLOCK_W - CRC_W){1'b0}}, i_crc};
      end else if (i_pair_valid) begin
        o_valid    <= 1'b1;
        o_iot_out  <= i_first;
        pend_valid <= 1'b1;
      end else if (pend_valid) begin
        o_valid   <= 1'b1;
        o_iot_out <= pend_q;
      end else begin
        // bus idles at zero
        o_valid   <= 1'b0;
        o_iot_out <= '0;
      end
    end
  end

  // at most a pair back to back
  a_valid_burst: assert property (
    @(posedge i_clk) disable iff (i_rst) not (o_valid [*3])
  );

endmodule

/* extreme_tracker.sv */
`timescale 1ns/1ps

module extreme_tracker import iotdf_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  block_t  i_block,
  input  logic    i_block_strobe,
  input  logic    i_group_last,
  input  fn_sel_t i_fn,
  output block_t  o_first,
  output block_t  o_second,
  output logic    o_pair_valid
);

  block_t first_q;
  block_t second_q;
  logic   seed_q;
  logic   is_max;
  logic   is_mm;
  logic   take;

  assign is_max = (i_fn == FN_TOP2MAX);
  assign is_mm  = is_max || (i_fn == FN_LAST2MIN);
  assign take   = i_block_strobe && is_mm;

  // seed flag marks the first block of the next group
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      seed_q       <= 1'b1;
      o_pair_valid <= 1'b0;
    end else begin
      o_pair_valid <= take && i_group_last;
      if (take) begin
        seed_q <= i_group_last;
      end
    end
  end

  // strict compares, ties never displace the leader
  always_ff @(posedge i_clk) begin
    if (take) begin
      if (seed_q) begin
        first_q  <= i_block;
        second_q <= is_max ? '0 : '1;
      end else if (is_max) begin
        if (i_block > first_q) begin
          second_q <= first_q;
          first_q  <= i_block;
        end else if (i_block > second_q) begin
          second_q <= i_block;
        end
      end else begin
        if (i_block < first_q) begin
          second_q <= first_q;
          first_q  <= i_block;
        end else if (i_block < second_q) begin
          second_q <= i_block;
        end
      end
    end
  end

  assign o_first  = first_q;
  assign o_second = second_q;

  // pair comes out ordered for the active function
  a_pair_ordered: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_pair_valid |-> (is_max ? (first_q >= second_q) : (first_q <= second_q))
  );

endmodule

/* crc3_unit.sv */
`timescale 1ns/1ps

module crc3_unit import iotdf_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  block_t  i_block,
  input  logic    i_block_strobe,
  input  fn_sel_t i_fn,
  output crc_t    o_crc,
  output logic    o_crc_valid
);

  crc_t crc_next;
  crc_t crc_q;
  logic calc;

  assign calc = i_block_strobe && (i_fn == FN_CRC_GEN);

  // long division, msb first, three zero bits appended implicitly
  always_comb begin
    logic fb;
    crc_next = '0;
    for (int i = BLOCK_W - 1; i >= 0; i--) begin
      fb       = crc_next[CRC_W-1] ^ i_block[i];
      crc_next = {crc_next[CRC_W-2:0], 1'b0};
      if (fb) begin
        crc_next = crc_next ^ CRC_POLY;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (calc) begin
      crc_q <= crc_next;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_crc_valid <= 1'b0;
    end else begin
      o_crc_valid <= calc;
    end
  end

  assign o_crc = crc_q;

  // blocks are at least 16 cycles apart
  a_crc_valid_pulse: assert property (
    @(posedge i_clk) disable iff (i_rst) o_crc_valid |=> !o_crc_valid
  );

endmodule

/* byte_loader.sv */
`timescale 1ns/1ps

module byte_loader import iotdf_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_in_en,
  input  byte_t   i_iot_in,
  input  fn_sel_t i_fn_sel,
  output block_t  o_block,
  output logic    o_block_strobe,
  output logic    o_group_last,
  output fn_sel_t o_fn,
  output logic    o_busy
);

  byte_idx_t  byte_idx;
  block_idx_t block_idx;
  fn_sel_t    fn_q;
  block_t     block_q;
  logic [1:0] busy_cnt;
  logic       accept;
  logic       last_byte;
  logic       minmax;
  logic       group_end;

  assign accept    = i_in_en && !o_busy;
  assign last_byte = accept && (byte_idx == byte_idx_t'(BYTES_PER_BLOCK - 1));
  assign minmax    = (fn_q == FN_TOP2MAX) || (fn_q == FN_LAST2MIN);

  // a crc group is a single block
  assign group_end = !minmax || (block_idx == block_idx_t'(BLOCKS_PER_GROUP - 1));

  // byte k goes to bits 8k+7:8k
  always_ff @(posedge i_clk) begin
    if (accept) begin
      block_q[byte_idx*BYTE_W +: BYTE_W] <= i_iot_in;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      byte_idx       <= '0;
      block_idx      <= '0;
      fn_q           <= FN_CRC_GEN;
      o_block_strobe <= 1'b0;
      o_group_last   <= 1'b0;
    end else begin
      o_block_strobe <= last_byte;
      o_group_last   <= last_byte && group_end;
      if (accept) begin
        byte_idx <= byte_idx + 1'b1;
        // function is taken with the first byte of a group
        if (byte_idx == '0 && block_idx == '0) begin
          fn_q <= i_fn_sel;
        end
      end
      if (last_byte) begin
        block_idx <= group_end ? '0 : block_idx + 1'b1;
      end
    end
  end

  // hold off the host while the pair drains out
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_busy   <= 1'b0;
      busy_cnt <= '0;
    end else if (last_byte && minmax && group_end) begin
      o_busy   <= 1'b1;
      busy_cnt <= 2'(BUSY_CYCLES - 1);
    end else if (o_busy) begin
      if (busy_cnt == '0) begin
        o_busy <= 1'b0;
      end else begin
        busy_cnt <= busy_cnt - 1'b1;
      end
    end
  end

  assign o_block = block_q;
  assign o_fn    = fn_q;

  // host must respect busy
  a_no_input_when_busy: assert property (
    @(posedge i_clk) disable iff (i_rst) o_busy |-> !i_in_en
  );

endmodule

/* iotdf_pkg.sv */
package iotdf_pkg;

  // stream geometry
  localparam int BYTE_W           = 8;
  localparam int BLOCK_W          = 128;
  localparam int BYTES_PER_BLOCK  = 16;
  localparam int BLOCKS_PER_GROUP = 8;

  // crc of block * x^3 mod (x^3 + x^2 + 1)
  localparam int CRC_W = 3;
  localparam logic [CRC_W-1:0] CRC_POLY = 3'b101;

  // busy window after the last byte of a min/max group
  localparam int BUSY_CYCLES = 4;

  typedef logic [BYTE_W-1:0]  byte_t;
  typedef logic [BLOCK_W-1:0] block_t;
  typedef logic [CRC_W-1:0]   crc_t;

  // position of a byte in its block
  typedef logic [$clog2(BYTES_PER_BLOCK)-1:0] byte_idx_t;

  // position of a block in its group
  typedef logic [$clog2(BLOCKS_PER_GROUP)-1:0] block_idx_t;

  // function codes, 1 and 2 are no longer decoded
  typedef enum logic [2:0] {
    FN_CRC_GEN  = 3'd3,
    FN_TOP2MAX  = 3'd4,
    FN_LAST2MIN = 3'd5
  } fn_sel_t;

endpackage
